//--- hdl/bridge_pkg.sv
package bridge_pkg;

    localparam int DEFAULT_ADDR_WIDTH  = 2;  // four words deep
    localparam int DEFAULT_SYNC_STAGES = 3;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_data_t;  // earlier byte in [7:0]

    typedef struct packed {
        logic       count;  // 0 one byte, 1 two bytes
        word_data_t data;
    } word_t;

    // pointers up to 8 bits travel through these helpers
    typedef logic [7:0] gray_vec_t;

    function automatic gray_vec_t gray_encode(input gray_vec_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic gray_vec_t gray_decode(input gray_vec_t gray);
        gray_vec_t bin;
        bin[7] = gray[7];
        for (int i = 6; i >= 0; i--) begin
            bin[i] = bin[i + 1] ^ gray[i];  // prefix xor from msb
        end
        return bin;
    endfunction

endpackage

//--- hdl/word_port_if.sv
interface word_port_if;

    bridge_pkg::word_t word;
    logic              strobe;  // push or pop
    logic              status;  // full or empty
    logic              stall;   // local reset / back-pressure level

    // word is driven by the packer on the write side
    // and only read by the unpacker on the read side
    modport stage (
        output word,
        output strobe,
        input  status,
        input  stall
    );

    modport fifo_wr (
        input  word,
        input  strobe,
        output status,
        output stall
    );

    modport fifo_rd (
        output word,
        input  strobe,
        output status,
        output stall
    );

endinterface

//--- hdl/byte_packer.sv
module byte_packer (
    input  logic              wclk,
    input  logic              wrst,
    input  logic              byte_valid_i,
    input  bridge_pkg::byte_t byte_i,
    input  logic              flush_i,
    output logic              busy_o,
    word_port_if.stage        wr
);

    typedef enum logic [1:0] {IDLE, HALF, HOLD} state_t;

    state_t            state_q;
    state_t            state_nxt;
    bridge_pkg::byte_t pend_q;     // low byte waiting for its partner
    bridge_pkg::word_t out_q;
    bridge_pkg::word_t word_nxt;
    logic              push;
    logic              load_word;
    logic              load_pair;

    assign push   = (state_q == HOLD) && !wr.stall;
    assign busy_o = (state_q == HOLD) && wr.status;

    ////////////////////////////////////////////////////////////
    // next state and output word
    always_comb begin
        state_nxt = state_q;
        load_word = 1'b0;
        load_pair = 1'b0;
        case (state_q)
            IDLE: begin
                if (byte_valid_i && flush_i) begin
                    load_word = 1'b1;  // lone byte flushed at once
                    state_nxt = HOLD;
                end else if (byte_valid_i) begin
                    state_nxt = HALF;
                end
            end
            HALF: begin
                if (byte_valid_i) begin
                    load_word = 1'b1;
                    load_pair = 1'b1;
                    state_nxt = HOLD;
                end else if (flush_i) begin
                    load_word = 1'b1;
                    state_nxt = HOLD;
                end
            end
            HOLD: begin
                if (push) begin  // output register frees up this cycle
                    if (byte_valid_i && flush_i) begin
                        load_word = 1'b1;
                    end else if (byte_valid_i) begin
                        state_nxt = HALF;
                    end else begin
                        state_nxt = IDLE;
                    end
                end
            end
            default: state_nxt = IDLE;
        endcase

        word_nxt.count     = load_pair;
        word_nxt.data[7:0] = (state_q == HALF) ? pend_q : byte_i;
        word_nxt.data[15:8] = load_pair ? byte_i : 8'h00;
    end

    always_ff @(posedge wclk) begin
        if (wrst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    always_ff @(posedge wclk) begin
        if (byte_valid_i) pend_q <= byte_i;
        if (load_word) out_q <= word_nxt;
    end

    assign wr.word   = out_q;
    assign wr.strobe = push;

    a_no_byte_while_busy: assert property (
        @(posedge wclk) disable iff (wrst) busy_o |-> !byte_valid_i
    ) else $error("byte strobed while packer busy");

endmodule

//--- hdl/gray_ptr_sync.sv
module gray_ptr_sync #(
    parameter int PTR_WIDTH   = 3,
    parameter int SYNC_STAGES = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [PTR_WIDTH-1:0] gray_i,
    output logic [PTR_WIDTH-1:0] bin_o
);

    typedef logic [PTR_WIDTH-1:0] ptr_t;

    ptr_t                  sync_q [SYNC_STAGES];
    bridge_pkg::gray_vec_t bin_full;

    // only one bit changes per step, so each stage is safe to sample
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= gray_i;  // first flop sees the async input
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i - 1];
            end
        end
    end

    assign bin_full = bridge_pkg::gray_decode(
        bridge_pkg::gray_vec_t'(sync_q[SYNC_STAGES-1])
    );

    assign bin_o = bin_full[PTR_WIDTH-1:0];

endmodule

//--- hdl/async_word_fifo.sv
module async_word_fifo #(
    parameter int ADDR_WIDTH  = bridge_pkg::DEFAULT_ADDR_WIDTH,
    parameter int SYNC_STAGES = bridge_pkg::DEFAULT_SYNC_STAGES
) (
    input  logic         wclk,
    input  logic         wrst,
    input  logic         rclk,
    input  logic         rrst,
    word_port_if.fifo_wr wr,
    word_port_if.fifo_rd rd
);

    localparam int PTR_WIDTH = ADDR_WIDTH + 1;  // extra wrap bit
    localparam int DEPTH     = 1 << ADDR_WIDTH;

    typedef logic [PTR_WIDTH-1:0] ptr_t;

    bridge_pkg::word_t     mem [DEPTH];

    ptr_t                  waddr_q;
    ptr_t                  waddr_next;
    ptr_t                  wgray_q;
    bridge_pkg::gray_vec_t wgray_next;
    ptr_t                  rptr_wclk;   // read pointer seen on the write side
    logic                  full_q;

    ptr_t                  raddr_q;
    ptr_t                  raddr_next;
    ptr_t                  rgray_q;
    bridge_pkg::gray_vec_t rgray_next;
    ptr_t                  wptr_rclk;   // write pointer seen on the read side
    logic                  empty_q;

    ////////////////////////////////////////////////////////////
    // write side
    assign waddr_next = waddr_q + ptr_t'(wr.strobe);
    assign wgray_next = bridge_pkg::gray_encode(bridge_pkg::gray_vec_t'(waddr_next));

    always_ff @(posedge wclk) begin
        if (wrst) begin
            waddr_q <= '0;
            wgray_q <= '0;
            full_q  <= 1'b0;
        end else begin
            waddr_q <= waddr_next;
            wgray_q <= wgray_next[PTR_WIDTH-1:0];  // registered, glitch free
            full_q  <= (rptr_wclk[ADDR_WIDTH-1:0] == waddr_next[ADDR_WIDTH-1:0])
                    && (rptr_wclk[ADDR_WIDTH] != waddr_next[ADDR_WIDTH]);
        end
    end

    always_ff @(posedge wclk) begin
        if (wr.strobe) mem[waddr_q[ADDR_WIDTH-1:0]] <= wr.word;
    end

    assign wr.status = full_q;
    assign wr.stall  = full_q | wrst;  // packer idles in reset too

    ////////////////////////////////////////////////////////////
    // read side
    assign raddr_next = raddr_q + ptr_t'(rd.strobe);
    assign rgray_next = bridge_pkg::gray_encode(bridge_pkg::gray_vec_t'(raddr_next));

    always_ff @(posedge rclk) begin
        if (rrst) begin
            raddr_q <= '0;
            rgray_q <= '0;
            empty_q <= 1'b1;
        end else begin
            raddr_q <= raddr_next;
            rgray_q <= rgray_next[PTR_WIDTH-1:0];
            empty_q <= (wptr_rclk == raddr_next);
        end
    end

    assign rd.word   = mem[raddr_q[ADDR_WIDTH-1:0]];  // head, valid when not empty
    assign rd.status = empty_q;
    assign rd.stall  = rrst;

    ////////////////////////////////////////////////////////////
    // pointer crossings
    gray_ptr_sync #(
        .PTR_WIDTH   (PTR_WIDTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) wptr_sync_inst (
        .clk    (rclk),
        .rst    (rrst),
        .gray_i (wgray_q),
        .bin_o  (wptr_rclk)
    );

    gray_ptr_sync #(
        .PTR_WIDTH   (PTR_WIDTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) rptr_sync_inst (
        .clk    (wclk),
        .rst    (wrst),
        .gray_i (rgray_q),
        .bin_o  (rptr_wclk)
    );

    a_no_push_on_full: assert property (
        @(posedge wclk) disable iff (wrst) wr.strobe |-> !wr.status
    ) else $error("push while fifo full");

    a_no_pop_on_empty: assert property (
        @(posedge rclk) disable iff (rrst) rd.strobe |-> !rd.status
    ) else $error("pop while fifo empty");

endmodule

//--- hdl/byte_unpacker.sv
module byte_unpacker (
    input  logic              rclk,
    input  logic              rrst,
    input  logic              hold_i,
    output bridge_pkg::byte_t byte_o,
    output logic              byte_valid_o,
    word_port_if.stage        rd
);

    typedef enum logic [1:0] {EMPTY, LOW, HIGH} state_t;

    state_t            state_q;
    state_t            state_nxt;
    bridge_pkg::word_t buf_q;      // word being emitted
    logic              last_byte;
    logic              pop;

    // the byte on the output now is the last one of the held word
    assign last_byte = (state_q == HIGH) || ((state_q == LOW) && !buf_q.count);

    assign pop = !hold_i && !rd.status && !rd.stall
              && ((state_q == EMPTY) || last_byte);

    ////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = state_q;
        if (!hold_i) begin
            case (state_q)
                EMPTY: begin
                    if (pop) state_nxt = LOW;
                end
                LOW: begin
                    if (buf_q.count) begin
                        state_nxt = HIGH;
                    end else begin
                        state_nxt = pop ? LOW : EMPTY;  // back to back words
                    end
                end
                HIGH: begin
                    state_nxt = pop ? LOW : EMPTY;
                end
                default: state_nxt = EMPTY;
            endcase
        end
    end

    always_ff @(posedge rclk) begin
        if (rrst) begin
            state_q <= EMPTY;
        end else begin
            state_q <= state_nxt;
        end
    end

    always_ff @(posedge rclk) begin
        if (pop) buf_q <= rd.word;
    end

    assign byte_valid_o = ((state_q == LOW) || (state_q == HIGH)) && !hold_i;
    assign byte_o       = (state_q == HIGH) ? buf_q.data[15:8] : buf_q.data[7:0];

    assign rd.strobe = pop;

endmodule

//--- hdl/cdc_byte_bridge.sv
module cdc_byte_bridge #(
    parameter int ADDR_WIDTH  = bridge_pkg::DEFAULT_ADDR_WIDTH,
    parameter int SYNC_STAGES = bridge_pkg::DEFAULT_SYNC_STAGES
) (
    input  logic              wclk,
    input  logic              wrst,
    input  logic              rclk,
    input  logic              rrst,

    input  logic              byte_valid_i,
    input  bridge_pkg::byte_t byte_i,
    input  logic              flush_i,
    output logic              busy_o,

    input  logic              hold_i,
    output bridge_pkg::byte_t byte_o,
    output logic              byte_valid_o
);

    word_port_if wr_if ();  // wclk domain
    word_port_if rd_if ();  // rclk domain

    byte_packer byte_packer_inst (
        .wclk         (wclk),
        .wrst         (wrst),
        .byte_valid_i (byte_valid_i),
        .byte_i       (byte_i),
        .flush_i      (flush_i),
        .busy_o       (busy_o),
        .wr           (wr_if.stage)
    );

    async_word_fifo #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) async_word_fifo_inst (
        .wclk (wclk),
        .wrst (wrst),
        .rclk (rclk),
        .rrst (rrst),
        .wr   (wr_if.fifo_wr),
        .rd   (rd_if.fifo_rd)
    );

    byte_unpacker byte_unpacker_inst (
        .rclk         (rclk),
        .rrst         (rrst),
        .hold_i       (hold_i),
        .byte_o       (byte_o),
        .byte_valid_o (byte_valid_o),
        .rd           (rd_if.stage)
    );

endmodule

//--- tests/tb_cdc_byte_bridge.sv
module tb_cdc_byte_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    WCLK_HALF    = 5;
    localparam int    RCLK_HALF    = 7;
    localparam int    RANDOM_STEPS = 2000;
    localparam int    MAX_BYTES    = 32 + 1 + 64 + RANDOM_STEPS;  // upper bound
    localparam int    HOLD_LEN     = 4096;
    localparam longint WATCHDOG_NS = longint'(MAX_BYTES) * 20 * (2 * RCLK_HALF) + 2000;

    logic              wclk         = 1'b0;
    logic              rclk         = 1'b0;
    logic              wrst         = 1'b1;
    logic              rrst         = 1'b1;
    logic              byte_valid_i = 1'b0;
    bridge_pkg::byte_t byte_i       = '0;
    logic              flush_i      = 1'b0;
    logic              hold_i       = 1'b0;
    logic              busy_o;
    bridge_pkg::byte_t byte_o;
    logic              byte_valid_o;

    bridge_pkg::byte_t model [$];     // bytes sent, not yet received
    logic              hold_pattern [HOLD_LEN];
    logic [1:0]        hold_mode    = 2'd0;  // 0 low, 1 high, 2 random
    logic              hold_next;
    int                hold_idx     = 0;
    int                value_errors = 0;
    int                other_errors = 0;
    int                bytes_sent   = 0;

    always #WCLK_HALF wclk = ~wclk;
    always #RCLK_HALF rclk = ~rclk;  // unrelated to wclk

    cdc_byte_bridge cdc_byte_bridge_inst (
        .wclk         (wclk),
        .wrst         (wrst),
        .rclk         (rclk),
        .rrst         (rrst),
        .byte_valid_i (byte_valid_i),
        .byte_i       (byte_i),
        .flush_i      (flush_i),
        .busy_o       (busy_o),
        .hold_i       (hold_i),
        .byte_o       (byte_o),
        .byte_valid_o (byte_valid_o)
    );

    ////////////////////////////////////////////////////////////
    // compare tasks
    task automatic check_byte(input bridge_pkg::byte_t got, input bridge_pkg::byte_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: byte_o is %h, expected %h", $time, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_idle(input logic busy, input logic valid,
                              input logic busy_exp, input logic valid_exp);
        if (busy !== busy_exp) begin
            $display("** Error at %0t ns: busy_o is %b, expected %b", $time, busy, busy_exp);
            value_errors++;
        end
        if (valid !== valid_exp) begin
            $display("** Error at %0t ns: byte_valid_o is %b, expected %b",
                     $time, valid, valid_exp);
            value_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // write side drivers, always entered 1 ns after a wclk edge
    task automatic next_cycle();
        @(posedge wclk);
        #1;
        byte_valid_i = 1'b0;
        flush_i      = 1'b0;
    endtask

    task automatic drive_step(input logic valid, input bridge_pkg::byte_t value,
                              input logic flush);
        byte_valid_i = valid;
        byte_i       = value;
        flush_i      = flush;
        if (valid) begin
            model.push_back(value);
            bytes_sent++;
        end
        next_cycle();
    endtask

    task automatic send_byte();
        while (busy_o) next_cycle();
        drive_step(1'b1, bridge_pkg::byte_t'($urandom), 1'b0);
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (model.size() != 0 && n < max_cycles) begin
            next_cycle();
            n++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sink side, hold_i moves 1 ns after rclk
    always @(posedge rclk) begin
        hold_next = (hold_mode == 2'd1) || ((hold_mode == 2'd2) && hold_pattern[hold_idx]);
        hold_idx  = (hold_idx + 1) % HOLD_LEN;
        #1 hold_i = hold_next;
    end

    always @(negedge rclk) begin  // mid cycle, outputs settled
        if (!rrst && byte_valid_o === 1'b1) begin
            if (model.size() == 0) begin
                $display("byte %h came out at %0t ns although none was expected",
                         byte_o, $time);
                other_errors++;
            end else begin
                check_byte(byte_o, model.pop_front());
            end
        end
    end

    initial begin
        repeat (4) @(posedge rclk);
        #1 rrst = 1'b0;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(56));
        for (int i = 0; i < HOLD_LEN; i++) begin
            hold_pattern[i] = ($urandom % 4 == 0);
        end
        repeat (4) @(posedge wclk);
        #1 wrst = 1'b0;
        wait (!rrst);
        next_cycle();

        // quiet after reset
        repeat (20) begin
            check_idle(busy_o, byte_valid_o, 1'b0, 1'b0);
            next_cycle();
        end

        // even run of 32 bytes
        repeat (32) send_byte();
        wait_drain(400);

        // lone byte with flush, then an empty flush
        send_byte();
        drive_step(1'b0, '0, 1'b1);
        wait_drain(200);
        drive_step(1'b0, '0, 1'b1);
        repeat (40) next_cycle();

        // sink holds until the source sees busy
        hold_mode = 2'd1;
        for (int i = 0; i < 64 && !busy_o; i++) begin
            send_byte();
        end
        if (!busy_o) begin
            $display("busy_o never rose while the sink was holding");
            other_errors++;
        end
        hold_mode = 2'd0;
        while (busy_o) next_cycle();
        drive_step(1'b0, '0, 1'b1);  // nothing pending, harmless
        wait_drain(400);

        // random strobes, flushes and hold
        hold_mode = 2'd2;
        for (int i = 0; i < RANDOM_STEPS; i++) begin
            drive_step(($urandom % 3 != 0) && !busy_o, bridge_pkg::byte_t'($urandom),
                       ($urandom % 10 == 0));
        end
        hold_mode = 2'd0;
        while (busy_o) next_cycle();
        drive_step(1'b0, '0, 1'b1);
        wait_drain(2000);
        repeat (20) next_cycle();

        if (model.size() != 0) begin
            $display("%0d sent bytes never came out of the bridge", model.size());
            other_errors++;
        end
        $display("summary: %0d bytes sent, %0d value errors, %0d other errors",
                 bytes_sent, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- project.f
hdl/bridge_pkg.sv
hdl/word_port_if.sv
hdl/byte_packer.sv
hdl/gray_ptr_sync.sv
hdl/async_word_fifo.sv
hdl/byte_unpacker.sv
hdl/cdc_byte_bridge.sv
tests/tb_cdc_byte_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cdc_byte_bridge \
    -f project.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q -F "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
